// File: source/bpred_pkg.sv
package bpred_pkg;

  // Instruction class resolved in execute
  typedef enum logic [1:0] {
    OP_NONE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR
  } bpred_op_e;

  // 2-bit saturating counter
  // 0 and 1 predict not taken, 2 and 3 predict taken
  typedef logic [1:0] ctr_t;

  // Counter seed for an entry allocated on a miss
  localparam ctr_t CTR_INIT_TAKEN     = 2'd2;
  localparam ctr_t CTR_INIT_NOT_TAKEN = 2'd1;

  // Register indices for call and return detection
  // x0 discards the link, x1 and x5 are the standard link registers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_T0   = 5'd5;

endpackage

// File: source/bpred_ifs.sv
`timescale 1ns/10ps

// BTB training path from execute
interface btb_update_if #(
  parameter int XLEN = 32
);
  // Single-cycle strobe, written at the clock edge
  logic            update_en;
  logic [XLEN-1:0] update_pc;
  logic [XLEN-1:0] update_target;
  logic            update_taken;
  logic            update_is_return;

  modport ex (
    output update_en, update_pc, update_target, update_taken, update_is_return
  );

  modport btb (
    input update_en, update_pc, update_target, update_taken, update_is_return
  );
endinterface

// BTB read path for fetch
interface btb_lookup_if #(
  parameter int XLEN = 32
);
  logic [XLEN-1:0] lookup_pc;
  // Results are combinational from lookup_pc
  logic            hit;
  logic [XLEN-1:0] target;
  logic            taken;
  logic            is_return;

  modport fetch (output lookup_pc, input hit, target, taken, is_return);
  modport btb (input lookup_pc, output hit, target, taken, is_return);
endinterface

// Return address stack access
interface ras_if #(
  parameter int XLEN = 32
);
  // Push and pop are strobes from execute
  logic            push;
  logic [XLEN-1:0] push_addr;
  logic            pop;
  // Top of stack peek, also used by fetch
  logic [XLEN-1:0] top;
  logic            empty;

  modport ex (output push, push_addr, pop);
  modport ras (input push, push_addr, pop, output top, empty);
  modport fetch (input top, empty);
endinterface

// File: source/bpred_btb.sv
`timescale 1ns/10ps

module bpred_btb #(
  parameter int XLEN        = 32,
  parameter int BTB_ENTRIES = 16
) (
  input logic       clk,
  input logic       arst_n,
  btb_lookup_if.btb lookup,
  btb_update_if.btb update
);

  // Index sits just above the halfword bits, tag takes the rest
  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = XLEN - IDX_W - 2;

  // Per-entry state
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];
  bpred_pkg::ctr_t        ctr_q    [BTB_ENTRIES];
  logic [BTB_ENTRIES-1:0] ret_q;

  // Lookup address split
  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;

  // Update address split
  logic [IDX_W-1:0] up_idx;
  logic [TAG_W-1:0] up_tag;
  logic             up_hit;

  // One step toward the outcome, saturating at both ends
  function automatic bpred_pkg::ctr_t ctr_step(
    input bpred_pkg::ctr_t ctr,
    input logic            taken
  );
    bpred_pkg::ctr_t nxt;
    nxt = ctr;
    if (taken && (ctr != 2'd3)) begin
      nxt = ctr + 2'd1;
    end else if (!taken && (ctr != 2'd0)) begin
      nxt = ctr - 2'd1;
    end
    return nxt;
  endfunction

  // Fetch side read
  assign lk_idx = lookup.lookup_pc[IDX_W+1:2];
  assign lk_tag = lookup.lookup_pc[XLEN-1:IDX_W+2];

  // Hit needs a valid entry with a matching tag
  assign lookup.hit       = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign lookup.target    = target_q[lk_idx];
  // Upper counter bit is the taken prediction
  assign lookup.taken     = ctr_q[lk_idx][1];
  assign lookup.is_return = ret_q[lk_idx];

  // Execute side training
  assign up_idx = update.update_pc[IDX_W+1:2];
  assign up_tag = update.update_pc[XLEN-1:IDX_W+2];
  assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

  // Valid bits are the only reset state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (update.update_en) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (update.update_en) begin
      // Target refreshed on every update
      target_q[up_idx] <= update.update_target;
      ret_q[up_idx]    <= update.update_is_return;
      if (up_hit) begin
        // Train the existing entry
        ctr_q[up_idx] <= ctr_step(ctr_q[up_idx], update.update_taken);
      end else begin
        // Allocate, evicting whatever held this index
        tag_q[up_idx] <= up_tag;
        ctr_q[up_idx] <= update.update_taken ? bpred_pkg::CTR_INIT_TAKEN
                                             : bpred_pkg::CTR_INIT_NOT_TAKEN;
      end
    end
  end

endmodule

// File: source/bpred_ras.sv
`timescale 1ns/10ps

module bpred_ras #(
  parameter int XLEN      = 32,
  parameter int RAS_DEPTH = 4
) (
  input logic clk,
  input logic arst_n,
  ras_if.ras  ras
);

  localparam int PTR_W = $clog2(RAS_DEPTH);
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  // Return addresses, circular
  logic [XLEN-1:0]  stack_q [RAS_DEPTH];
  // Points at the current top entry
  logic [PTR_W-1:0] ptr_q;
  // Number of live entries
  logic [CNT_W-1:0] count_q;

  logic [PTR_W-1:0] ptr_inc;
  logic [PTR_W-1:0] ptr_dec;

  // Wrap explicitly so non power of two depths work
  assign ptr_inc = (ptr_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
  assign ptr_dec = (ptr_q == '0) ? PTR_W'(RAS_DEPTH - 1) : ptr_q - 1'b1;

  assign ras.top   = stack_q[ptr_q];
  assign ras.empty = (count_q == '0);

  // Pointer and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q   <= '0;
      count_q <= '0;
    end else if (ras.push && ras.pop) begin
      // Top replaced in place, an empty stack gains one entry
      if (count_q == '0) begin
        count_q <= CNT_W'(1);
      end
    end else if (ras.push) begin
      ptr_q <= ptr_inc;
      // Full stack drops the oldest entry
      if (count_q != CNT_W'(RAS_DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (ras.pop && (count_q != '0)) begin
      ptr_q   <= ptr_dec;
      count_q <= count_q - 1'b1;
    end
  end

  // Stack storage
  always_ff @(posedge clk) begin
    if (ras.push && ras.pop) begin
      stack_q[ptr_q] <= ras.push_addr;
    end else if (ras.push) begin
      stack_q[ptr_inc] <= ras.push_addr;
    end
  end

endmodule

// File: source/bpred_fetch.sv
`timescale 1ns/10ps

module bpred_fetch #(
  parameter int XLEN       = 32,
  parameter int BPRED      = 1,
  parameter int RAS_ENABLE = 1
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             fetch_valid,
  input  logic [XLEN-1:0]  fetch_pc,
  btb_lookup_if.fetch      lookup,
  ras_if.fetch             ras,
  output logic             pred_valid,
  output logic             pred_taken,
  output logic [XLEN-1:0]  pred_target
);

  // Prediction formed in the lookup cycle
  logic            taken_d;
  logic [XLEN-1:0] target_d;

  // Registered prediction
  logic            pred_valid_q;
  logic            pred_taken_q;
  logic [XLEN-1:0] pred_target_q;

  // BTB is indexed straight from the fetch PC
  assign lookup.lookup_pc = fetch_pc;

  if (BPRED != 0) begin : g_bpred
    always_comb begin
      taken_d  = 1'b0;
      target_d = '0;
      if (fetch_valid && lookup.hit) begin
        if (lookup.is_return) begin
          // Returns only predict with a live RAS entry
          if ((RAS_ENABLE != 0) && !ras.empty) begin
            taken_d  = 1'b1;
            target_d = ras.top;
          end
        end else if (lookup.taken) begin
          // Counter at 2 or 3
          taken_d  = 1'b1;
          target_d = lookup.target;
        end
      end
    end
  end else begin : g_no_bpred
    // Static not taken
    assign taken_d  = 1'b0;
    assign target_d = '0;
  end

  // Valid and taken flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pred_valid_q <= 1'b0;
      pred_taken_q <= 1'b0;
    end else begin
      pred_valid_q <= fetch_valid;
      pred_taken_q <= taken_d;
    end
  end

  // Target is zero whenever not taken
  always_ff @(posedge clk) begin
    pred_target_q <= target_d;
  end

  assign pred_valid  = pred_valid_q;
  assign pred_taken  = pred_taken_q;
  assign pred_target = pred_target_q;

endmodule

// File: source/bpred_ex.sv
`timescale 1ns/10ps

module bpred_ex #(
  parameter int XLEN       = 32,
  parameter int BPRED      = 1,
  parameter int BTB_ENABLE = 1,
  parameter int RAS_ENABLE = 1
) (
  input  logic                 ex_valid,
  input  bpred_pkg::bpred_op_e ex_op,
  input  logic [4:0]           ex_rd,
  input  logic                 ex_branch_taken,
  input  logic                 ex_pred_taken,
  input  logic [XLEN-1:0]      ex_pc,
  input  logic [XLEN-1:0]      ex_jb_target,
  input  logic [XLEN-1:0]      ex_pred_target,
  output logic                 mispredicted,
  output logic                 redirect_jump,
  output logic [XLEN-1:0]      redirect_pc,
  btb_update_if.ex             update,
  ras_if.ex                    ras
);

  // Class decode, qualified by valid
  logic is_branch;
  logic is_jal;
  logic is_jalr;
  logic is_return;
  logic is_call;
  logic [XLEN-1:0] pc_plus4;

  assign is_branch = ex_valid && (ex_op == bpred_pkg::OP_BRANCH);
  assign is_jal    = ex_valid && (ex_op == bpred_pkg::OP_JAL);
  assign is_jalr   = ex_valid && (ex_op == bpred_pkg::OP_JALR);

  // Return is JALR discarding the link
  assign is_return = is_jalr && (ex_rd == bpred_pkg::REG_ZERO);
  // Call links through ra or t0
  assign is_call   = (is_jal || is_jalr) &&
                     ((ex_rd == bpred_pkg::REG_RA) || (ex_rd == bpred_pkg::REG_T0));

  assign pc_plus4 = ex_pc + XLEN'(4);

  // Conditional branch direction check
  if (BPRED != 0) begin : g_mispred
    assign mispredicted = is_branch && (ex_pred_taken != ex_branch_taken);
  end else begin : g_no_mispred
    assign mispredicted = 1'b0;
  end

  // Jump redirect
  if (BPRED != 0 && RAS_ENABLE != 0) begin : g_jalr_check
    // JAL is handled ahead of execute
    // JALR redirects when missed or aimed elsewhere
    assign redirect_jump = is_jalr &&
                           (!ex_pred_taken || (ex_pred_target != ex_jb_target));
  end else if (BPRED != 0) begin : g_jalr_always
    // No RAS, so JALR is never predicted
    assign redirect_jump = is_jalr;
  end else begin : g_jump_always
    assign redirect_jump = is_jal || is_jalr;
  end

  // Corrected PC, zero outside a valid cycle
  always_comb begin
    redirect_pc = '0;
    if (ex_valid) begin
      if (redirect_jump || (is_branch && ex_branch_taken)) begin
        redirect_pc = ex_jb_target;
      end else begin
        redirect_pc = pc_plus4;
      end
    end
  end

  // BTB training for branches, JALs and returns
  if (BTB_ENABLE != 0) begin : g_btb_update
    assign update.update_en        = is_branch || is_jal || is_return;
    assign update.update_pc        = ex_pc;
    assign update.update_target    = ex_jb_target;
    assign update.update_is_return = is_return;
    // Unconditional transfers always train toward taken
    assign update.update_taken     = (is_jal || is_return) ? 1'b1 : ex_branch_taken;
  end else begin : g_no_btb_update
    assign update.update_en        = 1'b0;
    assign update.update_pc        = '0;
    assign update.update_target    = '0;
    assign update.update_is_return = 1'b0;
    assign update.update_taken     = 1'b0;
  end

  // RAS maintenance from resolved calls and returns
  if (RAS_ENABLE != 0) begin : g_ras
    assign ras.push      = is_call;
    assign ras.push_addr = pc_plus4;
    assign ras.pop       = is_return;
  end else begin : g_no_ras
    assign ras.push      = 1'b0;
    assign ras.push_addr = '0;
    assign ras.pop       = 1'b0;
  end

endmodule

// File: source/bpred_top.sv
`timescale 1ns/10ps

module bpred_top #(
  parameter int XLEN        = 32,
  parameter int BTB_ENTRIES = 16,
  parameter int RAS_DEPTH   = 4,
  parameter int BPRED       = 1,
  parameter int BTB_ENABLE  = 1,
  parameter int RAS_ENABLE  = 1
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // Fetch request
  input  logic                 fetch_valid,
  input  logic [XLEN-1:0]      fetch_pc,
  // Resolved instruction in execute
  input  logic                 ex_valid,
  input  bpred_pkg::bpred_op_e ex_op,
  input  logic [4:0]           ex_rd,
  input  logic [XLEN-1:0]      ex_pc,
  input  logic                 ex_branch_taken,
  input  logic [XLEN-1:0]      ex_jb_target,
  // Prediction carried down the pipe
  input  logic                 ex_pred_taken,
  input  logic [XLEN-1:0]      ex_pred_target,
  // Prediction, one cycle after fetch
  output logic                 pred_valid,
  output logic                 pred_taken,
  output logic [XLEN-1:0]      pred_target,
  // Execute results
  output logic                 mispredicted,
  output logic                 redirect_jump,
  output logic [XLEN-1:0]      redirect_pc
);

  btb_update_if #(.XLEN(XLEN)) btb_upd ();
  btb_lookup_if #(.XLEN(XLEN)) btb_lk ();
  ras_if        #(.XLEN(XLEN)) ras_bus ();

  // Fetch stage reads BTB and RAS
  bpred_fetch #(
    .XLEN      (XLEN),
    .BPRED     (BPRED),
    .RAS_ENABLE(RAS_ENABLE)
  ) u_fetch (
    .clk        (clk),
    .arst_n     (arst_n),
    .fetch_valid(fetch_valid),
    .fetch_pc   (fetch_pc),
    .lookup     (btb_lk.fetch),
    .ras        (ras_bus.fetch),
    .pred_valid (pred_valid),
    .pred_taken (pred_taken),
    .pred_target(pred_target)
  );

  bpred_btb #(
    .XLEN       (XLEN),
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .clk   (clk),
    .arst_n(arst_n),
    .lookup(btb_lk.btb),
    .update(btb_upd.btb)
  );

  bpred_ras #(
    .XLEN     (XLEN),
    .RAS_DEPTH(RAS_DEPTH)
  ) u_ras (
    .clk   (clk),
    .arst_n(arst_n),
    .ras   (ras_bus.ras)
  );

  // Execute stage trains BTB and RAS
  bpred_ex #(
    .XLEN      (XLEN),
    .BPRED     (BPRED),
    .BTB_ENABLE(BTB_ENABLE),
    .RAS_ENABLE(RAS_ENABLE)
  ) u_ex (
    .ex_valid       (ex_valid),
    .ex_op          (ex_op),
    .ex_rd          (ex_rd),
    .ex_branch_taken(ex_branch_taken),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pc          (ex_pc),
    .ex_jb_target   (ex_jb_target),
    .ex_pred_target (ex_pred_target),
    .mispredicted   (mispredicted),
    .redirect_jump  (redirect_jump),
    .redirect_pc    (redirect_pc),
    .update         (btb_upd.ex),
    .ras            (ras_bus.ex)
  );

endmodule

// File: dv/bpred_sva.sv
`timescale 1ns/10ps

module bpred_sva #(
  parameter int XLEN        = 32,
  parameter int BTB_ENTRIES = 16,
  parameter int RAS_DEPTH   = 4
) (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 fetch_valid,
  input logic [XLEN-1:0]      fetch_pc,
  input logic                 ex_valid,
  input bpred_pkg::bpred_op_e ex_op,
  input logic [4:0]           ex_rd,
  input logic [XLEN-1:0]      ex_pc,
  input logic                 ex_branch_taken,
  input logic [XLEN-1:0]      ex_jb_target,
  input logic                 ex_pred_taken,
  input logic [XLEN-1:0]      ex_pred_target,
  input logic                 pred_valid,
  input logic                 pred_taken,
  input logic [XLEN-1:0]      pred_target,
  input logic                 mispredicted,
  input logic                 redirect_jump,
  input logic [XLEN-1:0]      redirect_pc
);

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = XLEN - IDX_W - 2;

  // Running tally, read by the testbench
  int fail_count = 0;

  // Shadow BTB
  logic [BTB_ENTRIES-1:0] sh_valid;
  logic [BTB_ENTRIES-1:0] sh_ret;
  logic [TAG_W-1:0]       sh_tag    [BTB_ENTRIES];
  logic [XLEN-1:0]        sh_target [BTB_ENTRIES];
  bpred_pkg::ctr_t        sh_ctr    [BTB_ENTRIES];

  // Shadow RAS, entry 0 is the top
  logic [XLEN-1:0] sh_ras [RAS_DEPTH];
  int              sh_depth;

  // Execute side decode
  logic             x_branch;
  logic             x_jal;
  logic             x_jalr;
  logic             x_return;
  logic             x_call;
  logic             x_train;
  logic             x_taken;
  logic [IDX_W-1:0] x_idx;
  logic [TAG_W-1:0] x_tag;
  logic             x_hit;

  // Fetch side expectation
  logic [IDX_W-1:0] f_idx;
  logic [TAG_W-1:0] f_tag;
  logic             exp_taken;
  logic [XLEN-1:0]  exp_target;
  logic             fetch_q;
  logic             exp_taken_q;
  logic [XLEN-1:0]  exp_target_q;

  // Execute side expectation
  logic             exp_mispred;
  logic             exp_redirect;
  logic [XLEN-1:0]  exp_redirect_pc;

  assign x_branch = ex_valid && (ex_op == bpred_pkg::OP_BRANCH);
  assign x_jal    = ex_valid && (ex_op == bpred_pkg::OP_JAL);
  assign x_jalr   = ex_valid && (ex_op == bpred_pkg::OP_JALR);
  // x0 link means return, x1 or x5 link means call
  assign x_return = x_jalr && (ex_rd == bpred_pkg::REG_ZERO);
  assign x_call   = (x_jal || x_jalr) &&
                    ((ex_rd == bpred_pkg::REG_RA) || (ex_rd == bpred_pkg::REG_T0));
  assign x_train  = x_branch || x_jal || x_return;
  // Jumps always train toward taken
  assign x_taken  = (x_jal || x_return) ? 1'b1 : ex_branch_taken;
  assign x_idx    = ex_pc[IDX_W+1:2];
  assign x_tag    = ex_pc[XLEN-1:IDX_W+2];
  assign x_hit    = sh_valid[x_idx] && (sh_tag[x_idx] == x_tag);

  assign exp_mispred  = x_branch && (ex_pred_taken != ex_branch_taken);
  assign exp_redirect = x_jalr && (!ex_pred_taken || (ex_pred_target != ex_jb_target));
  assign exp_redirect_pc = !ex_valid ? '0 :
                           (exp_redirect || (x_branch && ex_branch_taken)) ? ex_jb_target :
                           ex_pc + XLEN'(4);

  // Prediction rule against shadow state
  always_comb begin
    f_idx      = fetch_pc[IDX_W+1:2];
    f_tag      = fetch_pc[XLEN-1:IDX_W+2];
    exp_taken  = 1'b0;
    exp_target = '0;
    if (sh_valid[f_idx] && (sh_tag[f_idx] == f_tag)) begin
      if (sh_ret[f_idx]) begin
        if (sh_depth != 0) begin
          exp_taken  = 1'b1;
          exp_target = sh_ras[0];
        end
      end else if (sh_ctr[f_idx] >= 2'd2) begin
        exp_taken  = 1'b1;
        exp_target = sh_target[f_idx];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sh_valid     <= '0;
      sh_depth     <= 0;
      fetch_q      <= 1'b0;
      exp_taken_q  <= 1'b0;
      exp_target_q <= '0;
    end else begin
      // Fetch at this edge sees the state before any update here
      fetch_q      <= fetch_valid;
      exp_taken_q  <= fetch_valid && exp_taken;
      exp_target_q <= exp_target;
      if (x_train) begin
        sh_valid[x_idx]  <= 1'b1;
        sh_tag[x_idx]    <= x_tag;
        sh_target[x_idx] <= ex_jb_target;
        sh_ret[x_idx]    <= x_return;
        if (!x_hit) begin
          sh_ctr[x_idx] <= x_taken ? bpred_pkg::CTR_INIT_TAKEN : bpred_pkg::CTR_INIT_NOT_TAKEN;
        end else if (x_taken && (sh_ctr[x_idx] != 2'd3)) begin
          sh_ctr[x_idx] <= sh_ctr[x_idx] + 2'd1;
        end else if (!x_taken && (sh_ctr[x_idx] != 2'd0)) begin
          sh_ctr[x_idx] <= sh_ctr[x_idx] - 2'd1;
        end
      end
      if (x_call) begin
        // Oldest entry falls off the bottom when full
        for (int i = RAS_DEPTH - 1; i > 0; i--) begin
          sh_ras[i] <= sh_ras[i-1];
        end
        sh_ras[0] <= ex_pc + XLEN'(4);
        if (sh_depth < RAS_DEPTH) begin
          sh_depth <= sh_depth + 1;
        end
      end else if (x_return && (sh_depth > 0)) begin
        for (int i = 0; i < RAS_DEPTH - 1; i++) begin
          sh_ras[i] <= sh_ras[i+1];
        end
        sh_depth <= sh_depth - 1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> (!pred_valid && !mispredicted && !redirect_jump))
    else begin
      fail_count++;
      $error("MISMATCH %0t pred_valid/mispredicted/redirect_jump got %b%b%b exp 000",
             $time, pred_valid, mispredicted, redirect_jump);
    end

  a_pred_valid: assert property (@(posedge clk) disable iff (!arst_n) pred_valid == fetch_q)
    else begin
      fail_count++;
      $error("MISMATCH %0t pred_valid got %b exp %b", $time, pred_valid, fetch_q);
    end

  a_pred_taken: assert property (@(posedge clk) disable iff (!arst_n)
    pred_valid |-> (pred_taken == exp_taken_q))
    else begin
      fail_count++;
      $error("MISMATCH %0t pred_taken got %b exp %b", $time, pred_taken, exp_taken_q);
    end

  // Target reads zero on a not taken prediction
  a_pred_target: assert property (@(posedge clk) disable iff (!arst_n)
    pred_valid |-> (pred_target == exp_target_q))
    else begin
      fail_count++;
      $error("MISMATCH %0t pred_target got %h exp %h", $time, pred_target, exp_target_q);
    end

  a_mispred: assert property (@(posedge clk) disable iff (!arst_n) mispredicted == exp_mispred)
    else begin
      fail_count++;
      $error("MISMATCH %0t mispredicted got %b exp %b", $time, mispredicted, exp_mispred);
    end

  a_redirect_jump: assert property (@(posedge clk) disable iff (!arst_n)
    redirect_jump == exp_redirect)
    else begin
      fail_count++;
      $error("MISMATCH %0t redirect_jump got %b exp %b", $time, redirect_jump, exp_redirect);
    end

  a_redirect_pc: assert property (@(posedge clk) disable iff (!arst_n)
    redirect_pc == exp_redirect_pc)
    else begin
      fail_count++;
      $error("MISMATCH %0t redirect_pc got %h exp %h", $time, redirect_pc, exp_redirect_pc);
    end

endmodule

bind bpred_top bpred_sva #(
  .XLEN       (XLEN),
  .BTB_ENTRIES(BTB_ENTRIES),
  .RAS_DEPTH  (RAS_DEPTH)
) chk0 (
  .clk            (clk),
  .arst_n         (arst_n),
  .fetch_valid    (fetch_valid),
  .fetch_pc       (fetch_pc),
  .ex_valid       (ex_valid),
  .ex_op          (ex_op),
  .ex_rd          (ex_rd),
  .ex_pc          (ex_pc),
  .ex_branch_taken(ex_branch_taken),
  .ex_jb_target   (ex_jb_target),
  .ex_pred_taken  (ex_pred_taken),
  .ex_pred_target (ex_pred_target),
  .pred_valid     (pred_valid),
  .pred_taken     (pred_taken),
  .pred_target    (pred_target),
  .mispredicted   (mispredicted),
  .redirect_jump  (redirect_jump),
  .redirect_pc    (redirect_pc)
);

// File: dv/bpred_tb.sv
`timescale 1ns/10ps

module bpred_tb;

  localparam int XLEN         = 32;
  localparam int BTB_ENTRIES  = 16;
  localparam int PRED_TIMEOUT = 8;
  localparam int RAND_BRANCHES = 40;

  logic                 clk;
  logic                 arst_n;
  logic                 fetch_valid;
  logic [XLEN-1:0]      fetch_pc;
  logic                 ex_valid;
  bpred_pkg::bpred_op_e ex_op;
  logic [4:0]           ex_rd;
  logic [XLEN-1:0]      ex_pc;
  logic                 ex_branch_taken;
  logic [XLEN-1:0]      ex_jb_target;
  logic                 ex_pred_taken;
  logic [XLEN-1:0]      ex_pred_target;
  logic                 pred_valid;
  logic                 pred_taken;
  logic [XLEN-1:0]      pred_target;
  logic                 mispredicted;
  logic                 redirect_jump;
  logic [XLEN-1:0]      redirect_pc;

  int          timeout_count;
  int          test_num;
  int          mark;
  int          total;
  logic [31:0] r_pc;
  logic [31:0] r_tgt;
  logic [31:0] r_ptgt;
  logic [31:0] r_bits;

  bpred_top dut0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .ex_valid       (ex_valid),
    .ex_op          (ex_op),
    .ex_rd          (ex_rd),
    .ex_pc          (ex_pc),
    .ex_branch_taken(ex_branch_taken),
    .ex_jb_target   (ex_jb_target),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pred_target (ex_pred_target),
    .pred_valid     (pred_valid),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .mispredicted   (mispredicted),
    .redirect_jump  (redirect_jump),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Assertion failures plus wait timeouts
  function automatic int total_failures();
    return dut0.chk0.fail_count + timeout_count;
  endfunction

  // One execute cycle, then idle
  // Opcode and operands stay on the bus so outputs must follow ex_valid alone
  task automatic resolve(input bpred_pkg::bpred_op_e op, input logic [4:0] rd,
                         input logic [XLEN-1:0] pc, input logic taken,
                         input logic [XLEN-1:0] target, input logic ptaken,
                         input logic [XLEN-1:0] ptarget);
    @(posedge clk);
    ex_valid        <= 1'b1;
    ex_op           <= op;
    ex_rd           <= rd;
    ex_pc           <= pc;
    ex_branch_taken <= taken;
    ex_jb_target    <= target;
    ex_pred_taken   <= ptaken;
    ex_pred_target  <= ptarget;
    @(posedge clk);
    ex_valid <= 1'b0;
  endtask

  // Single fetch strobe, returns once the prediction is out
  // Prediction is polled mid-cycle while it is stable
  task automatic fetch(input logic [XLEN-1:0] pc);
    int waited;
    @(posedge clk);
    fetch_valid <= 1'b1;
    fetch_pc    <= pc;
    @(posedge clk);
    fetch_valid <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!pred_valid && (waited < PRED_TIMEOUT)) begin
      @(negedge clk);
      waited++;
    end
    if (!pred_valid) begin
      timeout_count++;
      $display("Timeout at %0t: no prediction came back for fetch of %h", $time, pc);
    end
  endtask

  // Per-test line, read away from the clock edge
  task automatic end_test(input string name);
    int fails;
    @(negedge clk);
    fails = total_failures() - mark;
    $display("test %0d %-14s %0d failure(s)", test_num, name, fails);
    test_num++;
    mark = total_failures();
  endtask

  initial begin
    r_bits          = $urandom(32'hc2e6);
    arst_n          = 1'b0;
    fetch_valid     = 1'b0;
    fetch_pc        = '0;
    ex_valid        = 1'b0;
    ex_op           = bpred_pkg::OP_NONE;
    ex_rd           = 5'd0;
    ex_pc           = '0;
    ex_branch_taken = 1'b0;
    ex_jb_target    = '0;
    ex_pred_taken   = 1'b0;
    ex_pred_target  = '0;
    timeout_count   = 0;
    test_num        = 1;
    mark            = 0;

    // Reset, then a cold fetch
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    r_pc = $urandom();
    fetch(r_pc & ~32'h3);
    end_test("reset");

    // Random branches with random carried predictions
    for (int n = 0; n < RAND_BRANCHES; n++) begin
      r_pc   = $urandom();
      r_tgt  = $urandom();
      r_ptgt = $urandom();
      r_bits = $urandom();
      resolve(bpred_pkg::OP_BRANCH, 5'd0, r_pc & ~32'h3, r_bits[0],
              r_tgt & ~32'h3, r_bits[1], r_ptgt & ~32'h3);
    end
    end_test("branch");

    // JALR hit, wrong target, no prediction; then a plain JAL
    resolve(bpred_pkg::OP_JALR, 5'd10, 32'h3000, 1'b1, 32'h3800, 1'b1, 32'h3800);
    resolve(bpred_pkg::OP_JALR, 5'd10, 32'h3000, 1'b1, 32'h3800, 1'b1, 32'h3900);
    resolve(bpred_pkg::OP_JALR, 5'd10, 32'h3000, 1'b1, 32'h3800, 1'b0, 32'h0);
    resolve(bpred_pkg::OP_JAL, 5'd0, 32'h3104, 1'b1, 32'h3400, 1'b0, 32'h0);
    end_test("jalr");

    // Walk one counter up then back down
    r_bits = 32'b00011;
    for (int n = 0; n < 5; n++) begin
      fetch(32'h0480);
      resolve(bpred_pkg::OP_BRANCH, 5'd0, 32'h0480, r_bits[n], 32'h0a00,
              pred_taken, pred_target);
    end
    fetch(32'h0480);
    end_test("counter");

    // Install the return, call, predict from RAS, then drain
    resolve(bpred_pkg::OP_JALR, bpred_pkg::REG_ZERO, 32'h0c44, 1'b1, 32'h0104, 1'b0, 32'h0);
    resolve(bpred_pkg::OP_JAL, bpred_pkg::REG_RA, 32'h0608, 1'b1, 32'h0c00, 1'b0, 32'h0);
    fetch(32'h0608);
    fetch(32'h0c44);
    resolve(bpred_pkg::OP_JALR, bpred_pkg::REG_ZERO, 32'h0c44, 1'b1, 32'h060c,
            pred_taken, pred_target);
    fetch(32'h0c44);
    end_test("call_return");

    // Same index, different tag
    resolve(bpred_pkg::OP_BRANCH, 5'd0, 32'h1010, 1'b1, 32'h2000, 1'b0, 32'h0);
    fetch(32'h1010);
    resolve(bpred_pkg::OP_BRANCH, 5'd0, 32'h1010 + BTB_ENTRIES * 4, 1'b1, 32'h2400,
            1'b0, 32'h0);
    fetch(32'h1010);
    fetch(32'h1010 + BTB_ENTRIES * 4);
    end_test("alias");

    repeat (3) @(posedge clk);
    @(negedge clk);
    total = total_failures();
    $display("summary: %0d tests, %0d assertion failure(s), %0d timeout(s)",
             test_num - 1, dut0.chk0.fail_count, timeout_count);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
source/bpred_pkg.sv
source/bpred_ifs.sv
source/bpred_btb.sv
source/bpred_ras.sv
source/bpred_fetch.sv
source/bpred_ex.sv
source/bpred_top.sv
dv/bpred_sva.sv
dv/bpred_tb.sv

// File: Makefile
# Verilator flow for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bpred_tb
RTL_TOP   ?= bpred_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
# Keep running past the first assertion so the testbench reports the total
SIM_ARGS  ?= +verilator+error+limit+100000
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		{ echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
